// ==== common/riscv_pkg.sv ====
package riscv_pkg;

    // Instruction word
    localparam int INSTR_W = 32;

    // Major opcode, bits 6:0 of every instruction
    typedef logic [6:0] opcode_t;

    // Register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // Opcodes handled by the memory end of the pipeline
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011; // ALU with immediate

    // Destination register field
    localparam int RD_LSB = 7;
    localparam int RD_MSB = 11;

endpackage

// ==== mem_stage/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int BITSIZE = 32
) (
    input  logic                          clk,
    input  logic                          resetn_i,

    // From execute
    input  logic                          ex_give_i,
    output logic                          ex_get_o,
    input  logic [riscv_pkg::INSTR_W-1:0] ex_instr_i,
    input  logic [BITSIZE-1:0]            ex_result_i,
    input  logic [BITSIZE-1:0]            ex_rs2_i,

    // Data memory request
    output logic [BITSIZE-1:0]            mem_addr_o,
    output logic [BITSIZE-1:0]            mem_wdata_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    input  logic [BITSIZE-1:0]            mem_rdata_i,
    input  logic                          mem_valid_i,

    // To writeback
    input  logic                          wb_get_i,
    output logic                          wb_give_o,
    output logic [riscv_pkg::INSTR_W-1:0] wb_instr_o,
    output logic [BITSIZE-1:0]            wb_data_o
);

    typedef enum logic [1:0] {
        GET,
        ACCESS,
        PROVIDE
    } state_t;

    state_t state_q, state_d;

    logic [riscv_pkg::INSTR_W-1:0] instr_q;
    logic [BITSIZE-1:0]            addr_q;   // Address or ALU result
    logic [BITSIZE-1:0]            rs2_q;    // Store data
    logic [BITSIZE-1:0]            data_q;   // Result handed to writeback
    logic                          is_load_q;
    logic                          is_store_q;

    riscv_pkg::opcode_t ex_opcode;
    logic               ex_is_load;
    logic               ex_is_store;
    logic               ex_is_mem;
    logic               ex_xfer;
    logic               wb_xfer;

    assign ex_opcode   = ex_instr_i[6:0];
    assign ex_is_load  = (ex_opcode == riscv_pkg::OPC_LOAD);
    assign ex_is_store = (ex_opcode == riscv_pkg::OPC_STORE);
    assign ex_is_mem   = ex_is_load || ex_is_store;

    assign ex_get_o  = (state_q == GET);
    assign ex_xfer   = ex_get_o && ex_give_i;

    // Give only while writeback is ready, so a transfer never waits
    assign wb_give_o = (state_q == PROVIDE) && wb_get_i;
    assign wb_xfer   = wb_give_o;

    // Request held steady for the whole ACCESS state
    assign mem_read_o  = (state_q == ACCESS) && is_load_q;
    assign mem_write_o = (state_q == ACCESS) && is_store_q;
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = rs2_q;

    assign wb_instr_o = instr_q;
    assign wb_data_o  = data_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            GET: begin
                if (ex_xfer) begin
                    state_d = ex_is_mem ? ACCESS : PROVIDE;
                end
            end
            ACCESS: begin
                if (mem_valid_i) begin
                    state_d = PROVIDE;
                end
            end
            PROVIDE: begin
                if (wb_xfer) begin
                    state_d = GET;
                end
            end
            default: state_d = GET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            state_q <= GET;
        end else begin
            state_q <= state_d;
        end
    end

    // Captured instruction and operands
    always_ff @(posedge clk) begin
        if (ex_xfer) begin
            instr_q    <= ex_instr_i;
            addr_q     <= ex_result_i;
            rs2_q      <= ex_rs2_i;
            is_load_q  <= ex_is_load;
            is_store_q <= ex_is_store;
        end
    end

    // Result source depends on the instruction class
    always_ff @(posedge clk) begin
        if (ex_xfer && !ex_is_mem) begin
            data_q <= ex_result_i;      // Pass-through
        end else if (mem_read_o && mem_valid_i) begin
            data_q <= mem_rdata_i;      // Load word
        end else if (mem_write_o && mem_valid_i) begin
            data_q <= addr_q;           // Store keeps its address
        end
    end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int BITSIZE    = 32,
    parameter int DEPTH_LOG2 = 8,
    parameter int LATENCY    = 2
) (
    input  logic               clk,
    input  logic               resetn_i,
    input  logic [BITSIZE-1:0] addr_i,
    input  logic [BITSIZE-1:0] wdata_i,
    input  logic               read_i,
    input  logic               write_i,
    output logic [BITSIZE-1:0] rdata_o,
    output logic               valid_o
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;
    localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    logic [BITSIZE-1:0]    mem [DEPTH];
    logic [DEPTH_LOG2-1:0] word_idx;
    logic [CNT_W-1:0]      wait_q;
    logic                  req;

    // Byte offset bits dropped, word accesses only
    assign word_idx = addr_i[DEPTH_LOG2+1:2];
    assign req      = read_i || write_i;

    // Strobe in the LATENCY-th cycle of a held request
    assign valid_o = req && (wait_q == CNT_W'(LATENCY - 1));

    always_ff @(posedge clk) begin
        if (!resetn_i || !req || valid_o) begin
            wait_q <= '0;
        end else begin
            wait_q <= wait_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_i && valid_o) begin
            mem[word_idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[word_idx]; // Sampled by the requester with valid_o

endmodule

// ==== hdl/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage #(
    parameter int BITSIZE = 32
) (
    input  logic                          clk,
    input  logic                          resetn_i,

    // From memory stage
    input  logic                          mem_give_i,
    output logic                          mem_get_o,
    input  logic [riscv_pkg::INSTR_W-1:0] instr_i,
    input  logic [BITSIZE-1:0]            data_i,

    // Commit port
    output logic                          retire_valid_o,
    output logic [riscv_pkg::INSTR_W-1:0] retire_instr_o,
    output riscv_pkg::reg_idx_t           retire_rd_o,
    output logic                          retire_we_o,
    output logic [BITSIZE-1:0]            retire_data_o
);

    typedef enum logic {
        IDLE,
        COMMIT
    } state_t;

    state_t state_q;

    logic [riscv_pkg::INSTR_W-1:0] instr_q;
    logic [BITSIZE-1:0]            data_q;
    riscv_pkg::opcode_t            opcode;

    assign mem_get_o = (state_q == IDLE);
    assign opcode    = instr_q[6:0];

    // One commit cycle per instruction, then ready again
    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            state_q <= IDLE;
        end else if (state_q == COMMIT) begin
            state_q <= IDLE;
        end else if (mem_give_i) begin
            state_q <= COMMIT;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_get_o && mem_give_i) begin
            instr_q <= instr_i;
            data_q  <= data_i;
        end
    end

    assign retire_valid_o = (state_q == COMMIT);
    assign retire_instr_o = instr_q;
    assign retire_rd_o    = instr_q[riscv_pkg::RD_MSB:riscv_pkg::RD_LSB];
    assign retire_data_o  = data_q;

    // Stores, branches and x0 leave the register file alone
    assign retire_we_o = (opcode != riscv_pkg::OPC_STORE)
                      && (opcode != riscv_pkg::OPC_BRANCH)
                      && (retire_rd_o != '0);

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int BITSIZE    = 32,
    parameter int DEPTH_LOG2 = 8,
    parameter int LATENCY    = 2
) (
    input  logic                          clk,
    input  logic                          resetn_i,

    input  logic                          ex_give_i,
    output logic                          ex_get_o,
    input  logic [riscv_pkg::INSTR_W-1:0] ex_instr_i,
    input  logic [BITSIZE-1:0]            ex_result_i,
    input  logic [BITSIZE-1:0]            ex_rs2_i,

    output logic                          retire_valid_o,
    output logic [riscv_pkg::INSTR_W-1:0] retire_instr_o,
    output riscv_pkg::reg_idx_t           retire_rd_o,
    output logic                          retire_we_o,
    output logic [BITSIZE-1:0]            retire_data_o
);

    // Memory port
    logic [BITSIZE-1:0] mem_addr;
    logic [BITSIZE-1:0] mem_wdata;
    logic [BITSIZE-1:0] mem_rdata;
    logic               mem_read;
    logic               mem_write;
    logic               mem_valid;

    // Memory stage to writeback
    logic                          wb_get;
    logic                          wb_give;
    logic [riscv_pkg::INSTR_W-1:0] wb_instr;
    logic [BITSIZE-1:0]            wb_data;

    mem_stage #(
        .BITSIZE (BITSIZE)
    ) u_mem (
        .clk         (clk),
        .resetn_i    (resetn_i),
        .ex_give_i   (ex_give_i),
        .ex_get_o    (ex_get_o),
        .ex_instr_i  (ex_instr_i),
        .ex_result_i (ex_result_i),
        .ex_rs2_i    (ex_rs2_i),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .mem_rdata_i (mem_rdata),
        .mem_valid_i (mem_valid),
        .wb_get_i    (wb_get),
        .wb_give_o   (wb_give),
        .wb_instr_o  (wb_instr),
        .wb_data_o   (wb_data)
    );

    data_ram #(
        .BITSIZE    (BITSIZE),
        .DEPTH_LOG2 (DEPTH_LOG2),
        .LATENCY    (LATENCY)
    ) u_ram (
        .clk      (clk),
        .resetn_i (resetn_i),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .read_i   (mem_read),
        .write_i  (mem_write),
        .rdata_o  (mem_rdata),
        .valid_o  (mem_valid)
    );

    wb_stage #(
        .BITSIZE (BITSIZE)
    ) u_wb (
        .clk            (clk),
        .resetn_i       (resetn_i),
        .mem_give_i     (wb_give),
        .mem_get_o      (wb_get),
        .instr_i        (wb_instr),
        .data_i         (wb_data),
        .retire_valid_o (retire_valid_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

// ==== testbench/mem_subsys_properties.sv ====
`timescale 1ns/1ps

module mem_subsys_properties (
    input logic clk,
    input logic resetn_i,
    input logic retire_valid_i,
    input logic mem_read_i,
    input logic mem_write_i,
    input logic mem_valid_i
);

    // Commit strobe is a single cycle
    a_retire_single: assert property (@(posedge clk) disable iff (!resetn_i)
        retire_valid_i |=> !retire_valid_i)
        else $error("retire_valid_o high for two cycles in a row");

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!resetn_i)
        !(mem_read_i && mem_write_i))
        else $error("memory read and write high together");

    // Requests held until the memory answers
    a_read_held: assert property (@(posedge clk) disable iff (!resetn_i)
        (mem_read_i && !mem_valid_i) |=> mem_read_i)
        else $error("memory read dropped before valid");

    a_write_held: assert property (@(posedge clk) disable iff (!resetn_i)
        (mem_write_i && !mem_valid_i) |=> mem_write_i)
        else $error("memory write dropped before valid");

    a_reset_quiet: assert property (@(posedge clk)
        !resetn_i |=> (!retire_valid_i && !mem_read_i && !mem_write_i))
        else $error("controls not low in the first cycle after reset");

endmodule

bind mem_subsys_top mem_subsys_properties u_props (
    .clk            (clk),
    .resetn_i       (resetn_i),
    .retire_valid_i (retire_valid_o),
    .mem_read_i     (mem_read),
    .mem_write_i    (mem_write),
    .mem_valid_i    (mem_valid)
);

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int BITSIZE        = 32;
    localparam int DEPTH_LOG2     = 6;
    localparam int LATENCY        = 3;
    localparam int NUM_TESTS      = 14;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (LATENCY + 10) + 50;

    logic                          clk;
    logic                          resetn_i;
    logic                          ex_give_i;
    logic                          ex_get_o;
    logic [riscv_pkg::INSTR_W-1:0] ex_instr_i;
    logic [BITSIZE-1:0]            ex_result_i;
    logic [BITSIZE-1:0]            ex_rs2_i;
    logic                          retire_valid_o;
    logic [riscv_pkg::INSTR_W-1:0] retire_instr_o;
    riscv_pkg::reg_idx_t           retire_rd_o;
    logic                          retire_we_o;
    logic [BITSIZE-1:0]            retire_data_o;

    // Stimulus table with expected rd and write enable
    logic [riscv_pkg::INSTR_W-1:0] tbl_instr  [NUM_TESTS];
    logic [BITSIZE-1:0]            tbl_result [NUM_TESTS];
    logic [BITSIZE-1:0]            tbl_rs2    [NUM_TESTS];
    riscv_pkg::reg_idx_t           tbl_rd     [NUM_TESTS];
    logic                          tbl_we     [NUM_TESTS];
    int                            tbl_fill;

    // Model memory and expected retires in issue order
    logic [BITSIZE-1:0]            model_mem [2**DEPTH_LOG2];
    logic [riscv_pkg::INSTR_W-1:0] exp_instr [$];
    riscv_pkg::reg_idx_t           exp_rd    [$];
    logic                          exp_we    [$];
    logic [BITSIZE-1:0]            exp_data  [$];

    int value_errors;
    int other_errors;
    int retire_count;

    mem_subsys_top #(
        .BITSIZE    (BITSIZE),
        .DEPTH_LOG2 (DEPTH_LOG2),
        .LATENCY    (LATENCY)
    ) u_dut (
        .clk            (clk),
        .resetn_i       (resetn_i),
        .ex_give_i      (ex_give_i),
        .ex_get_o       (ex_get_o),
        .ex_instr_i     (ex_instr_i),
        .ex_result_i    (ex_result_i),
        .ex_rs2_i       (ex_rs2_i),
        .retire_valid_o (retire_valid_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

    always #10 clk = ~clk;

    function automatic logic [riscv_pkg::INSTR_W-1:0] make_instr(input riscv_pkg::opcode_t opc,
                                                                 input riscv_pkg::reg_idx_t rd);
        return {20'h0a5c3, rd, opc}; // Upper bits are filler
    endfunction

    function automatic int word_index(input logic [BITSIZE-1:0] addr);
        return int'(addr[DEPTH_LOG2+1:2]);
    endfunction

    task automatic add_entry(input riscv_pkg::opcode_t opc, input riscv_pkg::reg_idx_t rd,
                             input logic we, input logic [BITSIZE-1:0] result,
                             input logic [BITSIZE-1:0] rs2);
        tbl_instr[tbl_fill]  = make_instr(opc, rd);
        tbl_result[tbl_fill] = result;
        tbl_rs2[tbl_fill]    = rs2;
        tbl_rd[tbl_fill]     = rd;
        tbl_we[tbl_fill]     = we;
        tbl_fill++;
    endtask

    task automatic fill_table();
        add_entry(riscv_pkg::OPC_OP_IMM, 5'd5,  1'b1, 32'h1234_5678, 32'h0);
        add_entry(riscv_pkg::OPC_STORE,  5'd2,  1'b0, 32'h0000_0040, 32'hdead_beef);
        add_entry(riscv_pkg::OPC_LOAD,   5'd6,  1'b1, 32'h0000_0040, 32'h0);
        add_entry(riscv_pkg::OPC_LOAD,   5'd7,  1'b1, 32'h0000_0043, 32'h0); // Low bits ignored
        add_entry(riscv_pkg::OPC_STORE,  5'd0,  1'b0, 32'h0000_0080, 32'h0bad_f00d);
        add_entry(riscv_pkg::OPC_STORE,  5'd4,  1'b0, 32'h0000_0044, 32'h1111_2222);
        add_entry(riscv_pkg::OPC_LOAD,   5'd8,  1'b1, 32'h0000_0080, 32'h0);
        add_entry(riscv_pkg::OPC_LOAD,   5'd9,  1'b1, 32'h0000_0044, 32'h0);
        add_entry(riscv_pkg::OPC_STORE,  5'd1,  1'b0, 32'h0000_0040, 32'h55aa_55aa);
        add_entry(riscv_pkg::OPC_LOAD,   5'd10, 1'b1, 32'h0000_0041, 32'h0);
        add_entry(riscv_pkg::OPC_OP_IMM, 5'd0,  1'b0, 32'h0000_cafe, 32'h0);
        add_entry(riscv_pkg::OPC_BRANCH, 5'd3,  1'b0, 32'h0000_0100, 32'h0);
        add_entry(riscv_pkg::OPC_OP_IMM, 5'd31, 1'b1, 32'hffff_ffff, 32'h0);
        add_entry(riscv_pkg::OPC_LOAD,   5'd1,  1'b1, 32'h0000_0082, 32'h0);
    endtask

    // Expected retire of one table entry and the model update of a store
    task automatic predict(input int idx);
        riscv_pkg::opcode_t opc;
        logic [BITSIZE-1:0] data;
        opc  = tbl_instr[idx][6:0];
        data = tbl_result[idx];
        if (opc == riscv_pkg::OPC_LOAD) begin
            data = model_mem[word_index(tbl_result[idx])];
        end
        if (opc == riscv_pkg::OPC_STORE) begin
            model_mem[word_index(tbl_result[idx])] = tbl_rs2[idx];
        end
        exp_instr.push_back(tbl_instr[idx]);
        exp_rd.push_back(tbl_rd[idx]);
        exp_we.push_back(tbl_we[idx]);
        exp_data.push_back(data);
    endtask

    task automatic check_data(input string name, input logic [BITSIZE-1:0] got,
                              input logic [BITSIZE-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_instr(input string name, input logic [riscv_pkg::INSTR_W-1:0] got,
                               input logic [riscv_pkg::INSTR_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_rd(input string name, input riscv_pkg::reg_idx_t got,
                            input riscv_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Retire strobe lasts one cycle, so one falling edge sees it
    always @(negedge clk) begin
        if (resetn_i && retire_valid_o) begin
            retire_count++;
            if (exp_data.size() == 0) begin
                $display("Retire at %0t with no instruction outstanding", $time);
                other_errors++;
            end else begin
                check_instr("retire_instr_o", retire_instr_o, exp_instr.pop_front());
                check_rd("retire_rd_o", retire_rd_o, exp_rd.pop_front());
                check_flag("retire_we_o", retire_we_o, exp_we.pop_front());
                check_data("retire_data_o", retire_data_o, exp_data.pop_front());
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(60602));
        clk          = 1'b0;
        resetn_i     = 1'b0;
        ex_give_i    = 1'b0;
        ex_instr_i   = '0;
        ex_result_i  = '0;
        ex_rs2_i     = '0;
        value_errors = 0;
        other_errors = 0;
        retire_count = 0;
        tbl_fill     = 0;
        fill_table();
        repeat (3) @(negedge clk);
        resetn_i = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            gap = $urandom_range(3, 0); // Zero gives back-to-back issue
            repeat (gap) @(negedge clk);
            while (!ex_get_o) @(negedge clk);
            predict(i);
            ex_give_i   = 1'b1;
            ex_instr_i  = tbl_instr[i];
            ex_result_i = tbl_result[i];
            ex_rs2_i    = tbl_rs2[i];
            @(negedge clk);
            ex_give_i = 1'b0;
        end
        wait (retire_count == NUM_TESTS);
        repeat (LATENCY + 10) @(negedge clk); // Room for a stray retire
        if (retire_count != NUM_TESTS) begin
            $display("Retired %0d instructions instead of %0d", retire_count, NUM_TESTS);
            other_errors++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        other_errors++;
        $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                 TIMEOUT_CYCLES, retire_count, NUM_TESTS);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
common/riscv_pkg.sv
mem_stage/mem_stage.sv
hdl/data_ram.sv
hdl/wb_stage.sv
hdl/mem_subsys_top.sv
testbench/mem_subsys_properties.sv
testbench/tb_mem_subsys.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f src.f
	out="$$(./obj_dir/Vtb_mem_subsys)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
